/* Bender.yml */
package:
  name: line_robot

sources:
  - rtl/robot_pkg.sv
  - rtl/drive_cmd_if.sv
  - rtl/range_finder.sv
  - rtl/steer_ctrl.sv
  - rtl/motor_drive.sv
  - rtl/line_robot_top.sv
  - target: test
    files:
      - bench/drive_checker.sv
      - bench/line_robot_properties.sv
      - bench/line_robot_tb.sv

/* bench/drive_checker.sv */
`timescale 1ns/1ps

module drive_checker import robot_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              trig,
  input  logic              left_pwm,
  input  logic              right_pwm,
  input  dir_t              left_dir,
  input  dir_t              right_dir,
  input  distance_t         distance,
  input  logic              check_req,
  input  int                test_id,
  input  dir_t              exp_left_dir,
  input  dir_t              exp_right_dir,
  input  logic [DUTY_W-1:0] exp_left_duty,
  input  logic [DUTY_W-1:0] exp_right_duty,
  input  distance_t         exp_dist,
  output logic              check_done,
  output int                pass_count,
  output int                fail_count,
  output int                trig_checked,
  output int                trig_errors
);

  // longest wait for distance or command to follow the stimulus
  localparam int SETTLE_CYCLES = 16;

  int   since_rise;
  logic trig_prev;

  // one full period of high samples, aligned on a rise when there is one
  task automatic measure_high(input bit use_right, output int high);
    int   n;
    bit   found;
    logic prev;
    logic cur;
    high  = 0;
    found = 1'b0;
    prev  = use_right ? right_pwm : left_pwm;
    // a flat output (duty 0 or full) never rises
    for (n = 0; n < PWM_PERIOD && !found; n++) begin
      @(negedge clk);
      cur   = use_right ? right_pwm : left_pwm;
      found = cur && !prev;
      prev  = cur;
    end
    for (n = 0; n < PWM_PERIOD; n++) begin
      if (use_right ? right_pwm : left_pwm) begin
        high++;
      end
      @(negedge clk);
    end
  endtask

  task automatic check_reset_state(output int errs);
    int   n;
    int   rises;
    logic lp;
    logic rp;
    errs  = 0;
    rises = 0;
    lp    = left_pwm;
    rp    = right_pwm;
    // sampled before the first post-reset clock edge
    if (left_dir !== DIR_STOP || right_dir !== DIR_STOP) begin
      $display("MISMATCH at %0t: directions %0d/%0d after reset, expected stop",
               $time, left_dir, right_dir);
      errs++;
    end
    // latched duties start at zero, first period stays flat
    for (n = 0; n < PWM_PERIOD; n++) begin
      @(negedge clk);
      if ((left_pwm && !lp) || (right_pwm && !rp)) begin
        rises++;
      end
      lp = left_pwm;
      rp = right_pwm;
    end
    if (rises != 0) begin
      $display("MISMATCH at %0t: %0d pwm rises in the first period after reset",
               $time, rises);
      errs++;
    end
  endtask

  task automatic check_drive(output int errs);
    int n;
    int left_high;
    int right_high;
    errs = 0;
    // distance lands a few cycles after the echo falls
    for (n = 0; n < SETTLE_CYCLES && distance !== exp_dist; n++) begin
      @(negedge clk);
    end
    if (distance !== exp_dist) begin
      $display("MISMATCH at %0t: test %0d distance %0d, expected %0d",
               $time, test_id, distance, exp_dist);
      errs++;
    end
    // command register trails obstacle and sensors by one clock
    for (n = 0; n < SETTLE_CYCLES &&
         (left_dir !== exp_left_dir || right_dir !== exp_right_dir); n++) begin
      @(negedge clk);
    end
    if (left_dir !== exp_left_dir || right_dir !== exp_right_dir) begin
      $display("MISMATCH at %0t: test %0d directions %0d/%0d, expected %0d/%0d",
               $time, test_id, left_dir, right_dir, exp_left_dir, exp_right_dir);
      errs++;
    end
    // new duty waits for the next counter wrap
    repeat (PWM_PERIOD + 2) @(negedge clk);
    measure_high(1'b0, left_high);
    measure_high(1'b1, right_high);
    if (left_high != int'(exp_left_duty) || right_high != int'(exp_right_duty)) begin
      $display("MISMATCH at %0t: test %0d pwm high %0d/%0d, expected %0d/%0d",
               $time, test_id, left_high, right_high, exp_left_duty, exp_right_duty);
      errs++;
    end
  endtask

  // request and done toggle on opposite clock edges
  always @(negedge clk) begin : check_loop
    int errs;
    if (reset) begin
      check_done = 1'b0;
      pass_count = 0;
      fail_count = 0;
    end else if (check_req && !check_done) begin
      if (test_id == 0) begin
        check_reset_state(errs);
      end else begin
        check_drive(errs);
      end
      if (errs == 0) begin
        pass_count++;
        $display("test %0d passed", test_id);
      end else begin
        fail_count++;
        $display("test %0d failed with %0d errors", test_id, errs);
      end
      check_done = 1'b1;
    end else if (!check_req) begin
      check_done = 1'b0;
    end
  end

  // trig rise spacing, first one counted from reset release
  always @(negedge clk) begin
    if (reset) begin
      since_rise   <= 0;
      trig_prev    <= 1'b0;
      trig_checked <= 0;
      trig_errors  <= 0;
    end else begin
      trig_prev <= trig;
      if (trig && !trig_prev) begin
        trig_checked <= trig_checked + 1;
        if (since_rise != TRIG_PERIOD) begin
          $display("MISMATCH at %0t: trig rise after %0d cycles, expected %0d",
                   $time, since_rise, TRIG_PERIOD);
          trig_errors <= trig_errors + 1;
        end
        since_rise <= 1;
      end else begin
        since_rise <= since_rise + 1;
      end
    end
  end

endmodule

/* bench/line_robot_cases.txt */
// sensors(left mid right) echo_cycles left_dir right_dir left_duty right_duty distance, hex
// a line whose first word is ff ends the list
7 0   1 1 64 64 fffff
6 0   0 1 0  64 fffff
4 0   0 1 0  64 fffff
3 0   1 0 64 0  fffff
1 0   1 0 64 0  fffff
0 0   2 2 4e 4e fffff
5 0   2 2 4e 4e fffff
2 0   2 2 4e 4e fffff
7 bb8 1 1 64 64 1434
7 9c4 1 1 64 64 10d6
7 3e8 0 0 0  0  6bc
3 0   0 0 0  0  6bc
3 90f 0 0 0  0  f9e
3 910 1 0 64 0  fa0
0 3a  0 0 0  0  64
6 fa0 0 1 0  64 1af0
ff 0  0 0 0  0  0

/* bench/line_robot_properties.sv */
`timescale 1ns/1ps

module line_robot_properties import robot_pkg::*; (
  input logic              clk,
  input logic              reset,
  input logic              trig,
  input logic              left_pwm,
  input logic              right_pwm,
  input logic [DUTY_W-1:0] left_duty,
  input logic [DUTY_W-1:0] right_duty
);

  // failed assertions seen by this instance
  int assert_fails = 0;

  // trig pulse holds for exactly TRIG_HIGH samples
  assert property (@(posedge clk) disable iff (reset)
    $rose(trig) |-> trig [*TRIG_HIGH] ##1 !trig)
    else begin
      $error("trig pulse width differs from %0d cycles", TRIG_HIGH);
      assert_fails++;
    end

  // output goes low the cycle after a zero duty is latched
  assert property (@(posedge clk) disable iff (reset) (left_duty == '0) |=> !left_pwm)
    else begin
      $error("left pwm high while its latched duty is zero");
      assert_fails++;
    end

  assert property (@(posedge clk) disable iff (reset) (right_duty == '0) |=> !right_pwm)
    else begin
      $error("right pwm high while its latched duty is zero");
      assert_fails++;
    end

  // async reset keeps trig low
  assert property (@(posedge clk) reset |-> !trig)
    else begin
      $error("trig high during reset");
      assert_fails++;
    end

endmodule

// ranger side with the pwm inputs tied off
bind range_finder line_robot_properties u_range_props (
  .clk        (clk),
  .reset      (reset),
  .trig       (trig),
  .left_pwm   (1'b0),
  .right_pwm  (1'b0),
  .left_duty  ('1),
  .right_duty ('1)
);

// motor side with trig tied low
bind motor_drive line_robot_properties u_motor_props (
  .clk        (clk),
  .reset      (reset),
  .trig       (1'b0),
  .left_pwm   (left_pwm),
  .right_pwm  (right_pwm),
  .left_duty  (left_duty_q),
  .right_duty (right_duty_q)
);

/* bench/line_robot_tb.sv */
`timescale 1ns/1ps

module line_robot_tb import robot_pkg::*; ();

  // words per line of the case file
  localparam int FIELDS     = 7;
  localparam int MAX_CASES  = 64;
  // echo starts this many cycles after a trig rise
  localparam int ECHO_DELAY = 20;

  logic      clk;
  logic      reset;
  logic      echo;
  logic      left_signal;
  logic      mid_signal;
  logic      right_signal;
  logic      trig;
  logic      left_pwm;
  logic      right_pwm;
  dir_t      left_dir;
  dir_t      right_dir;
  distance_t distance;

  // request and expectations for the checker
  logic              check_req;
  logic              check_done;
  int                test_id;
  dir_t              exp_left_dir;
  dir_t              exp_right_dir;
  logic [DUTY_W-1:0] exp_left_duty;
  logic [DUTY_W-1:0] exp_right_duty;
  distance_t         exp_dist;
  int                pass_count;
  int                fail_count;
  int                trig_checked;
  int                trig_errors;

  logic [31:0] case_mem [0:MAX_CASES*FIELDS-1];

  line_robot_top UUT (
    .clk          (clk),
    .reset        (reset),
    .echo         (echo),
    .left_signal  (left_signal),
    .mid_signal   (mid_signal),
    .right_signal (right_signal),
    .trig         (trig),
    .left_pwm     (left_pwm),
    .right_pwm    (right_pwm),
    .left_dir     (left_dir),
    .right_dir    (right_dir),
    .distance     (distance)
  );

  drive_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .trig           (trig),
    .left_pwm       (left_pwm),
    .right_pwm      (right_pwm),
    .left_dir       (left_dir),
    .right_dir      (right_dir),
    .distance       (distance),
    .check_req      (check_req),
    .test_id        (test_id),
    .exp_left_dir   (exp_left_dir),
    .exp_right_dir  (exp_right_dir),
    .exp_left_duty  (exp_left_duty),
    .exp_right_duty (exp_right_duty),
    .exp_dist       (exp_dist),
    .check_done     (check_done),
    .pass_count     (pass_count),
    .fail_count     (fail_count),
    .trig_checked   (trig_checked),
    .trig_errors    (trig_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // one clock plus the input setup delay
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_trig_rise(output bit ok);
    int   n;
    logic prev;
    ok = 1'b0;
    for (n = 0; n < TRIG_PERIOD + TRIG_HIGH + 4 && !ok; n++) begin
      prev = trig;
      step();
      ok = trig && !prev;
    end
    if (!ok) begin
      $display("timeout: no trig rise within %0d cycles", TRIG_PERIOD + TRIG_HIGH + 4);
    end
  endtask

  // raise the request, wait for done, then for the checker to let go
  task automatic request_check(output bit ok);
    int n;
    ok        = 1'b0;
    check_req = 1'b1;
    for (n = 0; n < 10 * PWM_PERIOD && !ok; n++) begin
      step();
      ok = check_done;
    end
    check_req = 1'b0;
    if (!ok) begin
      $display("timeout: checker did not finish test %0d", test_id);
    end else begin
      for (n = 0; n < 8 && check_done; n++) begin
        step();
      end
      if (check_done) begin
        $display("timeout: checker did not release test %0d", test_id);
        ok = 1'b0;
      end
    end
  endtask

  task automatic run_case(input int idx, output bit ok);
    int base;
    int width;
    base         = idx * FIELDS;
    width        = int'(case_mem[base+1]);
    ok           = 1'b1;
    left_signal  = case_mem[base][2];
    mid_signal   = case_mem[base][1];
    right_signal = case_mem[base][0];
    // zero width means no echo this test
    if (width != 0) begin
      wait_trig_rise(ok);
      if (ok) begin
        repeat (ECHO_DELAY) step();
        echo = 1'b1;
        repeat (width) step();
        echo = 1'b0;
      end
    end
    if (ok) begin
      test_id        = idx + 1;
      exp_left_dir   = dir_t'(case_mem[base+2][1:0]);
      exp_right_dir  = dir_t'(case_mem[base+3][1:0]);
      exp_left_duty  = case_mem[base+4][DUTY_W-1:0];
      exp_right_duty = case_mem[base+5][DUTY_W-1:0];
      exp_dist       = case_mem[base+6][ECHO_W-1:0];
      request_check(ok);
    end
  endtask

  initial begin : stimulus
    int idx;
    bit ok;
    bit run_error;
    int assert_fails;
    reset          = 1'b0;
    echo           = 1'b0;
    left_signal    = 1'b0;
    mid_signal     = 1'b0;
    right_signal   = 1'b0;
    check_req      = 1'b0;
    test_id        = 0;
    exp_left_dir   = DIR_STOP;
    exp_right_dir  = DIR_STOP;
    exp_left_duty  = DUTY_STOP;
    exp_right_duty = DUTY_STOP;
    exp_dist       = '1;
    $readmemh("bench/line_robot_cases.txt", case_mem);
    // reset spans the first two clock edges
    #1;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    // test 0 checks the reset state right after release
    request_check(ok);
    idx = 0;
    while (ok && idx < MAX_CASES && case_mem[idx * FIELDS] != 32'hFF) begin
      run_case(idx, ok);
      idx++;
    end
    run_error = !ok;
    if (idx == 0) begin
      $display("no test cases were read from the case file");
      run_error = 1'b1;
    end
    assert_fails = UUT.u_range.u_range_props.assert_fails
                 + UUT.u_motor.u_motor_props.assert_fails;
    $display("passed %0d, failed %0d, trig checked %0d, trig errors %0d, assert errors %0d",
             pass_count, fail_count, trig_checked, trig_errors, assert_fails);
    if (run_error || fail_count != 0 || trig_errors != 0 || trig_checked == 0 ||
        assert_fails != 0) begin
      $display("Test failures found");
    end else begin
      $display("All tests passed!");
    end
    $finish;
  end

endmodule

/* line_robot.f */
rtl/robot_pkg.sv
rtl/drive_cmd_if.sv
rtl/range_finder.sv
rtl/steer_ctrl.sv
rtl/motor_drive.sv
rtl/line_robot_top.sv
bench/drive_checker.sv
bench/line_robot_properties.sv
bench/line_robot_tb.sv

/* rtl/drive_cmd_if.sv */
`timescale 1ns/1ps

interface drive_cmd_if import robot_pkg::*; ();

  // wheel directions
  dir_t              left_dir;
  dir_t              right_dir;

  // high cycles per pwm period
  logic [DUTY_W-1:0] left_duty;
  logic [DUTY_W-1:0] right_duty;

  // steering side drives the command level
  modport src (
    output left_dir,
    output right_dir,
    output left_duty,
    output right_duty
  );

  // motor side only samples it
  modport dst (
    input left_dir,
    input right_dir,
    input left_duty,
    input right_duty
  );

endinterface

/* rtl/line_robot_top.sv */
`timescale 1ns/1ps

module line_robot_top import robot_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      echo,
  input  logic      left_signal,
  input  logic      mid_signal,
  input  logic      right_signal,
  output logic      trig,
  output logic      left_pwm,
  output logic      right_pwm,
  output dir_t      left_dir,
  output dir_t      right_dir,
  output distance_t distance
);

  // near obstacle level from the ranger
  logic obstacle;

  // registered drive command, steering to motors
  drive_cmd_if cmd_bus ();

  range_finder u_range (
    .clk      (clk),
    .reset    (reset),
    .echo     (echo),
    .trig     (trig),
    .distance (distance),
    .obstacle (obstacle)
  );

  steer_ctrl u_steer (
    .clk          (clk),
    .reset        (reset),
    .left_signal  (left_signal),
    .mid_signal   (mid_signal),
    .right_signal (right_signal),
    .obstacle     (obstacle),
    .cmd          (cmd_bus.src)
  );

  motor_drive u_motor (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd_bus.dst),
    .left_pwm  (left_pwm),
    .right_pwm (right_pwm)
  );

  // direction pins straight off the command
  assign left_dir  = cmd_bus.left_dir;
  assign right_dir = cmd_bus.right_dir;

endmodule

/* rtl/motor_drive.sv */
`timescale 1ns/1ps

module motor_drive import robot_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  drive_cmd_if.dst cmd,
  output logic     left_pwm,
  output logic     right_pwm
);

  // one period counter for both wheels
  logic [PWM_CNT_W-1:0] pwm_cnt;
  logic                 pwm_wrap;

  // duties held for a whole period
  logic [DUTY_W-1:0]    left_duty_q;
  logic [DUTY_W-1:0]    right_duty_q;

  assign pwm_wrap = (pwm_cnt == PWM_CNT_W'(PWM_PERIOD - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pwm_cnt <= '0;
    end else if (pwm_wrap) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  // new command only takes effect at a period boundary
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      left_duty_q  <= DUTY_STOP;
      right_duty_q <= DUTY_STOP;
    end else if (pwm_wrap) begin
      left_duty_q  <= cmd.left_duty;
      right_duty_q <= cmd.right_duty;
    end
  end

  // registered compare
  // output lags the counter by one, so each period sees one duty
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      left_pwm  <= 1'b0;
      right_pwm <= 1'b0;
    end else begin
      left_pwm  <= (pwm_cnt < PWM_CNT_W'(left_duty_q));
      right_pwm <= (pwm_cnt < PWM_CNT_W'(right_duty_q));
    end
  end

endmodule

/* rtl/range_finder.sv */
`timescale 1ns/1ps

module range_finder import robot_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      echo,
  output logic      trig,
  output distance_t distance,
  output logic      obstacle
);

  // trigger period counter
  logic [TRIG_CNT_W-1:0]  trig_cnt;
  logic                   trig_wrap;

  // echo sync chain plus one delay for edges
  logic                   echo_s1;
  logic                   echo_s2;
  logic                   echo_d;
  logic                   echo_rise;
  logic                   echo_fall;

  // pulse width in clock cycles
  logic [ECHO_W-1:0]      width_cnt;

  // scaling path
  logic [DIST_PROD_W-1:0] dist_prod;
  logic [DIST_PROD_W-1:0] dist_quot;
  distance_t              dist_next;

  assign trig_wrap = (trig_cnt == TRIG_CNT_W'(TRIG_PERIOD - 1));

  // first rise lands TRIG_PERIOD cycles out of reset
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      trig_cnt <= '0;
      trig     <= 1'b0;
    end else begin
      if (trig_wrap) begin
        trig_cnt <= '0;
        trig     <= 1'b1;
      end else begin
        trig_cnt <= trig_cnt + 1'b1;
        // high while the count runs 0 .. TRIG_HIGH-1
        if (trig_cnt == TRIG_CNT_W'(TRIG_HIGH - 1)) begin
          trig <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      echo_s1 <= 1'b0;
      echo_s2 <= 1'b0;
      echo_d  <= 1'b0;
    end else begin
      echo_s1 <= echo;
      echo_s2 <= echo_s1;
      echo_d  <= echo_s2;
    end
  end

  assign echo_rise = echo_s2 & ~echo_d;
  assign echo_fall = ~echo_s2 & echo_d;

  // restart at 1 on the rising edge so N high cycles count to N
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      width_cnt <= '0;
    end else if (echo_rise) begin
      width_cnt <= ECHO_W'(1);
    end else if (echo_s2 && (width_cnt != {ECHO_W{1'b1}})) begin
      width_cnt <= width_cnt + 1'b1;
    end
  end

  // speed of sound, round trip: cycles * 100 / 58, truncated
  assign dist_prod = DIST_PROD_W'(width_cnt) * DIST_PROD_W'(DIST_SCALE_NUM);
  assign dist_quot = dist_prod / DIST_PROD_W'(DIST_SCALE_DEN);
  // very long echoes clip to the clear-path value
  assign dist_next = (|dist_quot[DIST_PROD_W-1:ECHO_W]) ? {ECHO_W{1'b1}}
                                                         : dist_quot[ECHO_W-1:0];

  // clear path until the first real echo
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      distance <= {ECHO_W{1'b1}};
      obstacle <= 1'b0;
    end else if (echo_fall) begin
      distance <= dist_next;
      obstacle <= (dist_next < STOP_DIST);
    end
  end

endmodule

/* rtl/robot_pkg.sv */
package robot_pkg;

  // ultrasonic trigger, in clock cycles
  localparam int TRIG_PERIOD = 4000;
  localparam int TRIG_HIGH   = 10;
  localparam int TRIG_CNT_W  = $clog2(TRIG_PERIOD);

  // echo counter and distance width
  localparam int ECHO_W = 20;

  typedef logic [ECHO_W-1:0] distance_t;

  // obstacle threshold, hundredths of a cm (40 cm)
  localparam distance_t STOP_DIST = 20'd4000;

  // width * 100 / 58 gives hundredths of a cm
  localparam int DIST_SCALE_NUM = 100;
  localparam int DIST_SCALE_DEN = 58;
  // product needs room for the numerator bits
  localparam int DIST_PROD_W    = ECHO_W + $clog2(DIST_SCALE_NUM);

  // pwm period and duty encoding
  localparam int PWM_PERIOD = 100;
  localparam int PWM_CNT_W  = $clog2(PWM_PERIOD);
  localparam int DUTY_W     = 7;

  localparam logic [DUTY_W-1:0] DUTY_FAST = 7'd100;
  localparam logic [DUTY_W-1:0] DUTY_SLOW = 7'd78;
  localparam logic [DUTY_W-1:0] DUTY_STOP = 7'd0;

  // wheel direction pair, bit 1 backward, bit 0 forward
  typedef enum logic [1:0] {
    DIR_STOP = 2'b00,
    DIR_FWD  = 2'b01,
    DIR_BACK = 2'b10
  } dir_t;

  typedef enum logic [2:0] {
    MODE_STOP  = 3'd0,
    MODE_FWD   = 3'd1,
    MODE_LEFT  = 3'd2,
    MODE_RIGHT = 3'd3,
    MODE_BACK  = 3'd7
  } drive_mode_t;

endpackage

/* rtl/steer_ctrl.sv */
`timescale 1ns/1ps

module steer_ctrl import robot_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     left_signal,
  input  logic     mid_signal,
  input  logic     right_signal,
  input  logic     obstacle,
  drive_cmd_if.src cmd
);

  drive_mode_t mode;

  // sensor pattern is {left, mid, right}
  always_comb begin
    case ({left_signal, mid_signal, right_signal})
      3'b111:         mode = MODE_FWD;
      3'b110, 3'b100: mode = MODE_LEFT;
      3'b011, 3'b001: mode = MODE_RIGHT;
      // line lost or odd pattern, back off
      default:        mode = MODE_BACK;
    endcase
    // near obstacle wins over any sensor pattern
    if (obstacle) begin
      mode = MODE_STOP;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cmd.left_dir   <= DIR_STOP;
      cmd.right_dir  <= DIR_STOP;
      cmd.left_duty  <= DUTY_STOP;
      cmd.right_duty <= DUTY_STOP;
    end else begin
      case (mode)
        MODE_FWD: begin
          cmd.left_dir   <= DIR_FWD;
          cmd.right_dir  <= DIR_FWD;
          cmd.left_duty  <= DUTY_FAST;
          cmd.right_duty <= DUTY_FAST;
        end
        // pivot on the stopped left wheel
        MODE_LEFT: begin
          cmd.left_dir   <= DIR_STOP;
          cmd.right_dir  <= DIR_FWD;
          cmd.left_duty  <= DUTY_STOP;
          cmd.right_duty <= DUTY_FAST;
        end
        MODE_RIGHT: begin
          cmd.left_dir   <= DIR_FWD;
          cmd.right_dir  <= DIR_STOP;
          cmd.left_duty  <= DUTY_FAST;
          cmd.right_duty <= DUTY_STOP;
        end
        MODE_BACK: begin
          cmd.left_dir   <= DIR_BACK;
          cmd.right_dir  <= DIR_BACK;
          cmd.left_duty  <= DUTY_SLOW;
          cmd.right_duty <= DUTY_SLOW;
        end
        // MODE_STOP, directions and duties both dropped
        default: begin
          cmd.left_dir   <= DIR_STOP;
          cmd.right_dir  <= DIR_STOP;
          cmd.left_duty  <= DUTY_STOP;
          cmd.right_duty <= DUTY_STOP;
        end
      endcase
    end
  end

endmodule
